// File: sources.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/instruction_memory.sv
verilog/fetch.sv
verilog/fetch_queue.sv
verilog/jump_resolver.sv
verilog/fetch_subsystem.sv
verification/fetch_subsystem_tb.sv

// File: verification/fetch_input.txt
# T ready_percent starts a test with a reset, M address word loads one memory word
# E pc instruction is the next expected retirement, addresses and words in hex
T 100
M 0 00100093
M 4 00200113
M 8 00300193
M c 00400213
M 10 00500293
M 14 00600313
E 0 00100093
E 4 00200113
E 8 00300193
E c 00400213
E 10 00500293
E 14 00600313
T 100
M 0 00500293
M 4 00c0006f
M 10 00600313
M 14 00700393
E 0 00500293
E 10 00600313
E 14 00700393
T 100
M 0 00108093
M 4 0080006f
M c 00210113
M 10 0080006f
M 18 fe9ff06f
E 0 00108093
E c 00210113
E 0 00108093
E c 00210113
E 0 00108093
E c 00210113
E 0 00108093
E c 00210113
T 30
M 0 00100093
M 4 00200113
M 8 00300193
M c 00400213
M 10 00500293
M 14 00600313
E 0 00100093
E 4 00200113
E 8 00300193
E c 00400213
E 10 00500293
E 14 00600313

// File: verification/fetch_subsystem_tb.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_subsystem_tb;

    localparam int MAX_TESTS   = 16;
    localparam int MAX_RECORDS = 256;

    logic               clk;
    logic               reset_n;
    logic               run_i;
    logic               load_en_i;
    fetch_pkg::addr_t   load_addr_i;
    fetch_pkg::inst_t   load_data_i;
    fetch_pkg::retire_t retire_o;
    logic               retire_valid_o;
    logic               retire_ready_i;

    // Records from the input file grouped per test
    int                 test_ready     [MAX_TESTS];
    int                 test_mem_first [MAX_TESTS];
    int                 test_mem_count [MAX_TESTS];
    int                 test_exp_first [MAX_TESTS];
    int                 test_exp_count [MAX_TESTS];
    fetch_pkg::addr_t   mem_addr       [MAX_RECORDS];
    fetch_pkg::inst_t   mem_data       [MAX_RECORDS];
    fetch_pkg::retire_t exp_list       [MAX_RECORDS];
    int                 num_tests;
    int                 num_mem;
    int                 num_exp;
    logic               input_ok;
    logic               tests_started = 1'b0;

    logic [31:0]        lfsr_state;
    int                 test_errors;
    int                 total_errors;
    int                 tests_failed;

    fetch_subsystem fetch_subsystem_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .run_i          (run_i),
        .load_en_i      (load_en_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    // Ready with the given chance in percent from a 7-bit draw
    task automatic draw_ready(input int percent);
        int value;
        random_bits(7, value);
        retire_ready_i = (value * 100) < (percent * 128);
    endtask

    // addi x1, x0, imm with the address as immediate
    function automatic fetch_pkg::inst_t fill_word(input fetch_pkg::addr_t addr);
        return {addr[11:0], 5'd0, 3'd0, 5'd1, 7'h13};
    endfunction

    task automatic compare_values(input string name, input logic [63:0] actual,
                                  input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic load_word(input fetch_pkg::addr_t addr, input fetch_pkg::inst_t data);
        load_en_i   = 1'b1;
        load_addr_i = addr;
        load_data_i = data;
        @(negedge clk);
    endtask

    task automatic read_input_file;
        int          fd;
        int          code;
        int          ch;
        int          percent;
        logic [7:0]  kind;
        logic [31:0] first;
        logic [31:0] second;
        logic        done;
        num_tests = 0;
        num_mem   = 0;
        num_exp   = 0;
        input_ok  = 1'b1;
        done      = 1'b0;
        fd = $fopen("verification/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/fetch_input.txt");
            input_ok = 1'b0;
            done     = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                // Comment runs to the end of the line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (kind == "T") begin
                code = $fscanf(fd, "%d", percent);
                if (code != 1) begin
                    $display("Missing ready percent in the input file");
                    input_ok = 1'b0;
                    done     = 1'b1;
                end
                test_ready[num_tests]     = percent;
                test_mem_first[num_tests] = num_mem;
                test_mem_count[num_tests] = 0;
                test_exp_first[num_tests] = num_exp;
                test_exp_count[num_tests] = 0;
                num_tests++;
            end else if ((kind == "M" || kind == "E") && num_tests > 0) begin
                code = $fscanf(fd, "%h %h", first, second);
                if (code != 2) begin
                    $display("Incomplete %c record in the input file", kind);
                    input_ok = 1'b0;
                    done     = 1'b1;
                end
                if (kind == "M") begin
                    mem_addr[num_mem] = first;
                    mem_data[num_mem] = second;
                    num_mem++;
                    test_mem_count[num_tests-1]++;
                end else begin
                    exp_list[num_exp] = {first, second};
                    num_exp++;
                    test_exp_count[num_tests-1]++;
                end
            end else begin
                $display("Unexpected record %c in verification/fetch_input.txt", kind);
                input_ok = 1'b0;
                done     = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (num_tests == 0) begin
            $display("The input file holds no test");
            input_ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One test with reset, memory load, idle check, run and compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_test(input int t);
        int                 index;
        logic               held_valid;
        fetch_pkg::retire_t held_value;
        fetch_pkg::retire_t expected;
        fetch_pkg::addr_t   addr;
        test_errors = 0;
        @(negedge clk);
        reset_n        = 1'b0;
        run_i          = 1'b0;
        load_en_i      = 1'b0;
        retire_ready_i = 1'b0;
        repeat (5) @(negedge clk);
        reset_n        = 1'b1;
        retire_ready_i = 1'b1;
        @(negedge clk);
        compare_values("retire_valid_o", retire_valid_o, 1'b0);
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            addr = i * 4;
            load_word(addr, fill_word(addr));
        end
        for (int i = 0; i < test_mem_count[t]; i++) begin
            load_word(mem_addr[test_mem_first[t] + i], mem_data[test_mem_first[t] + i]);
        end
        load_en_i  = 1'b0;
        // Program in memory and nothing may retire while run_i is low
        repeat (20) begin
            @(negedge clk);
            compare_values("retire_valid_o", retire_valid_o, 1'b0);
        end
        run_i      = 1'b1;
        index      = 0;
        held_valid = 1'b0;
        held_value = '0;
        while (index < test_exp_count[t]) begin
            @(negedge clk);
            // Stalled word must stay put
            if (held_valid) begin
                compare_values("retire_valid_o", retire_valid_o, 1'b1);
                compare_values("retire_o", retire_o, held_value);
            end
            draw_ready(test_ready[t]);
            // Transfer happens at the coming rising edge
            if (retire_valid_o && retire_ready_i) begin
                expected = exp_list[test_exp_first[t] + index];
                compare_values("retire_o.pc", retire_o.pc, expected.pc);
                compare_values("retire_o.instruction", retire_o.instruction,
                               expected.instruction);
                index++;
            end
            held_valid = retire_valid_o && !retire_ready_i;
            held_value = retire_o;
        end
        @(negedge clk);
        run_i          = 1'b0;
        retire_ready_i = 1'b0;
        $display("Test %0d: ready %0d percent, %0d retirements, %0d errors",
                 t + 1, test_ready[t], index, test_errors);
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        run_i          = 1'b0;
        load_en_i      = 1'b0;
        load_addr_i    = '0;
        load_data_i    = '0;
        retire_ready_i = 1'b0;
        lfsr_state     = 32'h0ac841b2;
        total_errors   = 0;
        tests_failed   = 0;
        read_input_file();
        if (!input_ok) begin
            total_errors = 1;
        end else begin
            tests_started = 1'b1;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
        end
        $display("Tests run %0d, failed %0d, errors %0d", num_tests, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (tests_started);
        limit = 40 * num_exp + 100 * num_tests;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the expected retirements did not all arrive",
                 limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: verilog/fetch.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    run_i,
    input  fetch_pkg::redirect_t    redirect_i,
    input  logic                    credit_return_i,
    output logic                    imem_read_o,
    output fetch_pkg::addr_t        imem_addr_o,
    input  fetch_pkg::inst_t        imem_data_i,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t entry_o
);

    localparam int CREDIT_WIDTH = $clog2(`FETCH_QUEUE_DEPTH) + 1;

    fetch_pkg::addr_t        address;
    fetch_pkg::tag_t         tag;
    logic [CREDIT_WIDTH-1:0] credits;
    logic                    issue;

    fetch_pkg::addr_t        pc_r;
    fetch_pkg::tag_t         tag_r;
    logic                    issue_r;

    ////////////////////////////////////////////////////////////////////////////
    // Issue and credits
    ////////////////////////////////////////////////////////////////////////////

    // One credit per free queue slot
    assign issue = run_i && (credits != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credits <= CREDIT_WIDTH'(`FETCH_QUEUE_DEPTH);
        end else begin
            case ({credit_return_i, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address and tag
    ////////////////////////////////////////////////////////////////////////////

    // Redirect wins over sequential advance
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            address <= `RESET_ADDRESS;
        end else if (redirect_i.valid) begin
            address <= {redirect_i.target[31:2], 2'b00};
        end else if (issue) begin
            address <= address + 32'd4;
        end
    end

    // New epoch on every redirect
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag <= '0;
        end else if (redirect_i.valid) begin
            tag <= tag + 1'b1;
        end
    end

    assign imem_read_o = issue;
    assign imem_addr_o = address;

    ////////////////////////////////////////////////////////////////////////////
    // Alignment with memory data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_r <= 1'b0;
        end else begin
            issue_r <= issue;
        end
    end

    // Pc and tag of the word now in flight
    always_ff @(posedge clk) begin
        if (issue) begin
            pc_r  <= address;
            tag_r <= tag;
        end
    end

    assign push_o              = issue_r;
    assign entry_o.pc          = pc_r;
    assign entry_o.instruction = imem_data_i;
    assign entry_o.tag         = tag_r;

endmodule

// File: verilog/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Fetch queue slots, also the credit count fetch starts with
`define FETCH_QUEUE_DEPTH 4

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 64

// First fetch address after reset
`define RESET_ADDRESS 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTRUCTION 32'h0000_0013

`endif

// File: verilog/fetch_pkg.sv
package fetch_pkg;

    // Byte address
    typedef logic [31:0] addr_t;

    // Instruction word
    typedef logic [31:0] inst_t;

    // Redirect epoch, wraps around
    typedef logic [2:0] tag_t;

    // One fetched word with the pc and epoch it was issued under
    typedef struct packed {
        addr_t pc;
        inst_t instruction;
        tag_t  tag;
    } fetch_entry_t;

    // Control transfer request from the resolver
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // Retired instruction on the output port
    typedef struct packed {
        addr_t pc;
        inst_t instruction;
    } retire_t;

endpackage

// File: verilog/fetch_queue.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_queue (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    input  logic                    pop_i,
    output fetch_pkg::fetch_entry_t head_o,
    output logic                    not_empty_o,
    output logic                    credit_return_o
);

    localparam int PTR_WIDTH = $clog2(`FETCH_QUEUE_DEPTH);

    fetch_pkg::fetch_entry_t slots [`FETCH_QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [PTR_WIDTH:0]      count;
    logic                    do_pop;

    assign do_pop      = pop_i && not_empty_o;
    assign not_empty_o = (count != '0);
    assign head_o      = slots[rd_ptr];

    // Storage, a free slot is guaranteed by the credits
    always_ff @(posedge clk) begin
        if (push_i) begin
            slots[wr_ptr] <= entry_i;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back per consumed entry
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= do_pop;
        end
    end

endmodule

// File: verilog/fetch_subsystem.sv
`timescale 1ns/1ns

module fetch_subsystem (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               run_i,
    input  logic               load_en_i,
    input  fetch_pkg::addr_t   load_addr_i,
    input  fetch_pkg::inst_t   load_data_i,
    output fetch_pkg::retire_t retire_o,
    output logic               retire_valid_o,
    input  logic               retire_ready_i
);

    logic                    imem_read;
    fetch_pkg::addr_t        imem_addr;
    fetch_pkg::inst_t        imem_data;
    logic                    push;
    fetch_pkg::fetch_entry_t entry;
    logic                    pop;
    fetch_pkg::fetch_entry_t head;
    logic                    not_empty;
    logic                    credit_return;
    fetch_pkg::redirect_t    redirect;

    instruction_memory instruction_memory_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .read_en_i   (imem_read),
        .read_addr_i (imem_addr),
        .read_data_o (imem_data)
    );

    fetch fetch_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .run_i           (run_i),
        .redirect_i      (redirect),
        .credit_return_i (credit_return),
        .imem_read_o     (imem_read),
        .imem_addr_o     (imem_addr),
        .imem_data_i     (imem_data),
        .push_o          (push),
        .entry_o         (entry)
    );

    fetch_queue fetch_queue_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .push_i          (push),
        .entry_i         (entry),
        .pop_i           (pop),
        .head_o          (head),
        .not_empty_o     (not_empty),
        .credit_return_o (credit_return)
    );

    jump_resolver jump_resolver_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .head_i         (head),
        .not_empty_i    (not_empty),
        .pop_o          (pop),
        .redirect_o     (redirect),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i)
    );

endmodule

// File: verilog/instruction_memory.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module instruction_memory (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             load_en_i,
    input  fetch_pkg::addr_t load_addr_i,
    input  fetch_pkg::inst_t load_data_i,
    input  logic             read_en_i,
    input  fetch_pkg::addr_t read_addr_i,
    output fetch_pkg::inst_t read_data_o
);

    localparam int INDEX_WIDTH = $clog2(`IMEM_WORDS);

    fetch_pkg::inst_t       mem [`IMEM_WORDS];
    logic [INDEX_WIDTH-1:0] load_index;
    logic [INDEX_WIDTH-1:0] read_index;

    // Word index, byte offset bits dropped
    assign load_index = load_addr_i[INDEX_WIDTH+1:2];
    assign read_index = read_addr_i[INDEX_WIDTH+1:2];

    // Load port
    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem[load_index] <= load_data_i;
        end
    end

    // Read port, data valid one cycle after the strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_o <= `NOP_INSTRUCTION;
        end else if (read_en_i) begin
            read_data_o <= mem[read_index];
        end
    end

endmodule

// File: verilog/jump_resolver.sv
`timescale 1ns/1ns

module jump_resolver (
    input  logic                    clk,
    input  logic                    reset_n,
    input  fetch_pkg::fetch_entry_t head_i,
    input  logic                    not_empty_i,
    output logic                    pop_o,
    output fetch_pkg::redirect_t    redirect_o,
    output fetch_pkg::retire_t      retire_o,
    output logic                    retire_valid_o,
    input  logic                    retire_ready_i
);

    localparam logic [6:0] OPCODE_JAL = 7'b1101111;

    fetch_pkg::tag_t  expected_tag;
    fetch_pkg::inst_t inst;
    fetch_pkg::addr_t jal_offset;
    logic             current;
    logic             is_jal;
    logic             out_free;
    logic             take_retire;

    ////////////////////////////////////////////////////////////////////////////
    // Decode of the head entry
    ////////////////////////////////////////////////////////////////////////////

    assign inst    = head_i.instruction;
    assign current = (head_i.tag == expected_tag);
    assign is_jal  = (inst[6:0] == OPCODE_JAL);

    // J-type immediate
    assign jal_offset = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Output register can take a new word this cycle
    assign out_free = !retire_valid_o || retire_ready_i;

    // Stale and JAL entries never wait on the output port
    assign pop_o       = not_empty_i && (!current || is_jal || out_free);
    assign take_retire = not_empty_i && current && !is_jal && out_free;

    assign redirect_o.valid  = not_empty_i && current && is_jal;
    assign redirect_o.target = head_i.pc + jal_offset;

    // Follows the fetch tag across each redirect
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            expected_tag <= '0;
        end else if (redirect_o.valid) begin
            expected_tag <= expected_tag + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            retire_valid_o <= 1'b0;
        end else if (take_retire) begin
            retire_valid_o <= 1'b1;
        end else if (retire_ready_i) begin
            retire_valid_o <= 1'b0;
        end
    end

    // Held while valid and not ready
    always_ff @(posedge clk) begin
        if (take_retire) begin
            retire_o.pc          <= head_i.pc;
            retire_o.instruction <= inst;
        end
    end

endmodule
